// File: tb.f
+incdir+hw
hw/cache_pkg.sv
hw/tlb_pkg.sv
hw/dp_bram.sv
hw/lfsr.sv
hw/itlb.sv
hw/icache.sv
hw/ifetch_top.sv
verif/tb_clk_gen.sv
verif/icache_asserts.sv
verif/tb_top.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f tb.f \
    --top-module tb_top \
    --Mdir obj_dir -o sim_tb

./obj_dir/sim_tb

// File: verif/tb_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_macros.svh"

module tb_top
    import cache_pkg::*;
    import tlb_pkg::*;
;
    localparam int RAND_FETCHES = 8;
    localparam int NUM_TESTS    = 5 + RAND_FETCHES;

    logic                      clk;
    logic                      rst;
    logic                      rreq_1;
    logic                      rreq_2;
    fetch_addr_u               raddr_1;
    fetch_addr_u               raddr_2;
    logic                      rvalid_1;
    logic                      rvalid_2;
    logic [`ICACHE_LINE_W-1:0] rdata_1;
    logic [`ICACHE_LINE_W-1:0] rdata_2;
    tlb_req_t                  tlb_req;
    tlb_wr_t                   tlb_wr;
    mem_req_t                  mem_req;
    mem_rsp_t                  mem_rsp;

    integer                    seed;
    logic [31:0]               req_log [$];
    int                        req_count;
    int                        lat1;
    int                        lat2;
    logic [`ICACHE_LINE_W-1:0] got1;
    logic [`ICACHE_LINE_W-1:0] got2;

    tb_clk_gen #(.PERIOD(40)) u_clk (.clk(clk));

    ifetch_top dut_i (
        .clk       (clk),
        .rst       (rst),
        .rreq_1_i  (rreq_1),
        .raddr_1_i (raddr_1),
        .rvalid_1_o(rvalid_1),
        .rdata_1_o (rdata_1),
        .rreq_2_i  (rreq_2),
        .raddr_2_i (raddr_2),
        .rvalid_2_o(rvalid_2),
        .rdata_2_o (rdata_2),
        .tlb_req_i (tlb_req),
        .tlb_wr_i  (tlb_wr),
        .mem_req_o (mem_req),
        .mem_rsp_i (mem_rsp)
    );

    bind icache icache_asserts u_asserts (
        .clk       (clk),
        .rst       (rst),
        .mem_req_i (mem_req_o),
        .mem_rsp_i (mem_rsp_i),
        .tmiss_i   (tmiss),
        .rvalid_1_i(rvalid_1_o),
        .rvalid_2_i(rvalid_2_o),
        .rdata_1_i (rdata_1_o),
        .rdata_2_i (rdata_2_o)
    );

    //////////////////////////////////////////////////////////////////////
    // Memory model
    //////////////////////////////////////////////////////////////////////

    // Word i of a line is the line address plus i
    function automatic logic [`ICACHE_LINE_W-1:0] model_line(input logic [31:0] pa);
        logic [`ICACHE_LINE_W-1:0] line;
        logic [31:0]               base;
        base = {pa[31:4], 4'h0};
        for (int i = 0; i < 4; i++) begin
            line[32*i +: 32] = base + 32'(i);
        end
        return line;
    endfunction

    initial begin : mem_model
        logic [31:0] addr;
        int          delay;
        forever begin
            @(negedge clk);
            if (!rst && mem_req.req) begin
                addr = mem_req.addr;
                req_log.push_back(addr);
                req_count++;
                // Back-pressure before ready
                delay = $unsigned($random(seed)) % 4;
                repeat (delay) @(negedge clk);
                mem_rsp.rdy = 1'b1;
                @(negedge clk);
                mem_rsp.rdy = 1'b0;
                delay = 1 + $unsigned($random(seed)) % 8;
                repeat (delay) @(negedge clk);
                mem_rsp.rvalid = 1'b1;
                mem_rsp.data = model_line(addr);
                @(negedge clk);
                mem_rsp.rvalid = 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////////////////////////

    task automatic check_line(input string name, input logic [`ICACHE_LINE_W-1:0] exp,
                              input logic [`ICACHE_LINE_W-1:0] act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
            $display("RESULT: FAIL");
            $fatal(1, "line data mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
            $display("RESULT: FAIL");
            $fatal(1, "flag mismatch");
        end
    endtask

    task automatic check_addr(input string name, input fetch_addr_u exp,
                              input fetch_addr_u act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
            $display("RESULT: FAIL");
            $fatal(1, "address mismatch");
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Drivers
    //////////////////////////////////////////////////////////////////////

    // Issue one fetch pair and wait for each requested port's valid pulse
    task automatic do_fetch(input logic r1, input logic [31:0] a1, input logic r2,
                            input logic [31:0] a2, input logic ten);
        logic done1;
        logic done2;
        int   cyc;
        done1 = !r1;
        done2 = !r2;
        cyc = 0;
        rreq_1 = r1;
        rreq_2 = r2;
        raddr_1 = a1;
        raddr_2 = a2;
        tlb_req.trans_en = ten;
        tlb_req.vaddr = a1;
        while (!(done1 && done2)) begin
            @(negedge clk);
            cyc++;
            if (cyc == 1) begin
                rreq_1 = 1'b0;
                rreq_2 = 1'b0;
            end
            if (rvalid_1 && !done1) begin
                done1 = 1'b1;
                lat1 = cyc;
                got1 = rdata_1;
            end
            if (rvalid_2 && !done2) begin
                done2 = 1'b1;
                lat2 = cyc;
                got2 = rdata_2;
            end
        end
    endtask

    task automatic write_tlb(input logic [TLB_IDX_W-1:0] idx, input logic [19:0] vpn,
                             input logic [19:0] ppn);
        tlb_wr.we = 1'b1;
        tlb_wr.idx = idx;
        tlb_wr.valid = 1'b1;
        tlb_wr.vpn = vpn;
        tlb_wr.ppn = ppn;
        @(negedge clk);
        tlb_wr.we = 1'b0;
    endtask

    task automatic clear_log();
        req_log.delete();
        req_count = 0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////////////////////////

    task automatic test_cold_miss();
        clear_log();
        do_fetch(1'b1, 32'h0000_1230, 1'b0, 32'h0, 1'b0);
        check_line("cold_miss data", model_line(32'h0000_1230), got1);
        check_bit("cold_miss one request", 1'b1, req_count == 1);
        check_addr("cold_miss mem addr", 32'h0000_1230, req_log[0]);
        clear_log();
        do_fetch(1'b1, 32'h0000_1234, 1'b0, 32'h0, 1'b0);
        check_bit("hit latency", 1'b1, lat1 == 1);
        check_line("hit data", model_line(32'h0000_1230), got1);
        check_bit("hit no request", 1'b1, req_count == 0);
    endtask

    task automatic test_translation();
        fetch_addr_u va;
        fetch_addr_u pa;
        va = 32'h0004_0560;
        pa.page.vpn = 20'h00123;
        pa.page.offset = va.page.offset;
        write_tlb(3'd0, va.page.vpn, pa.page.vpn);
        clear_log();
        do_fetch(1'b1, va, 1'b0, 32'h0, 1'b1);
        check_bit("translation one request", 1'b1, req_count == 1);
        check_addr("translation mem addr", pa, req_log[0]);
        check_line("translation data", model_line(pa), got1);
    endtask

    task automatic test_tlb_miss();
        clear_log();
        do_fetch(1'b1, 32'h0009_9000, 1'b1, 32'h0009_9100, 1'b1);
        check_bit("tlb_miss port 1 latency", 1'b1, lat1 == 1);
        check_bit("tlb_miss port 2 latency", 1'b1, lat2 == 1);
        repeat (2) @(negedge clk);
        check_bit("tlb_miss no request", 1'b1, req_count == 0);
    endtask

    task automatic test_dual_miss();
        clear_log();
        do_fetch(1'b1, 32'h0000_2040, 1'b1, 32'h0000_2080, 1'b0);
        check_bit("dual_miss two requests", 1'b1, req_count == 2);
        check_addr("dual_miss first addr", 32'h0000_2040, req_log[0]);
        check_addr("dual_miss second addr", 32'h0000_2080, req_log[1]);
        check_line("dual_miss port 1 data", model_line(32'h0000_2040), got1);
        check_line("dual_miss port 2 data", model_line(32'h0000_2080), got2);
    endtask

    // Back to back over the lines filled by the dual miss
    task automatic test_streaming();
        logic [31:0] a1;
        logic [31:0] a2;
        clear_log();
        for (int k = 0; k < 8; k++) begin
            a1 = k[0] ? 32'h0000_2080 : 32'h0000_2040;
            a2 = k[0] ? 32'h0000_2044 : 32'h0000_2088;
            rreq_1 = 1'b1;
            rreq_2 = 1'b1;
            raddr_1 = a1;
            raddr_2 = a2;
            tlb_req.trans_en = 1'b0;
            tlb_req.vaddr = a1;
            @(negedge clk);
            check_bit("streaming port 1 valid", 1'b1, rvalid_1);
            check_bit("streaming port 2 valid", 1'b1, rvalid_2);
            check_line("streaming port 1 data", model_line(a1), rdata_1);
            check_line("streaming port 2 data", model_line(a2), rdata_2);
        end
        rreq_1 = 1'b0;
        rreq_2 = 1'b0;
        check_bit("streaming no request", 1'b1, req_count == 0);
    endtask

    task automatic test_random();
        logic [31:0] r;
        logic [31:0] a1;
        logic [31:0] a2;
        for (int i = 0; i < RAND_FETCHES; i++) begin
            r = $random(seed);
            a1 = {20'h00005, 4'h0, r[3:0], r[7:4]};
            a2 = {20'h00005, 4'h0, r[11:8], r[15:12]};
            do_fetch(1'b1, a1, 1'b1, a2, 1'b0);
            check_line("random port 1 data", model_line(a1), got1);
            check_line("random port 2 data", model_line(a2), got2);
        end
    endtask

    initial begin : watchdog
        #(NUM_TESTS * 2000);
        $display("RESULT: FAIL");
        $fatal(1, "Watchdog timeout, the tests did not finish in time");
    end

    initial begin
        seed = 32'h8f0f_0ad8;
        rst = 1'b1;
        rreq_1 = 1'b0;
        rreq_2 = 1'b0;
        raddr_1 = '0;
        raddr_2 = '0;
        tlb_req = '0;
        tlb_wr = '0;
        mem_rsp = '0;
        req_count = 0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        test_cold_miss();
        test_translation();
        test_tlb_miss();
        test_dual_miss();
        test_streaming();
        test_random();
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/icache_asserts.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_macros.svh"

module icache_asserts
    import cache_pkg::*;
(
    input logic                      clk,
    input logic                      rst,
    input mem_req_t                  mem_req_i,
    input mem_rsp_t                  mem_rsp_i,
    input logic [1:0]                tmiss_i,
    input logic                      rvalid_1_i,
    input logic                      rvalid_2_i,
    input logic [`ICACHE_LINE_W-1:0] rdata_1_i,
    input logic [`ICACHE_LINE_W-1:0] rdata_2_i
);
    // Address held while memory applies back-pressure
    addr_stable: assert property (@(posedge clk) disable iff (rst)
        mem_req_i.req && !mem_rsp_i.rdy |=> $stable(mem_req_i.addr))
        else $error("memory address changed while waiting for ready");

    no_req_after_tmiss: assert property (@(posedge clk) disable iff (rst)
        |tmiss_i |=> !mem_req_i.req)
        else $error("memory request after a TLB miss");

    data_known_1: assert property (@(posedge clk) disable iff (rst)
        rvalid_1_i |-> !$isunknown(rdata_1_i))
        else $error("port 1 data has unknown bits");

    data_known_2: assert property (@(posedge clk) disable iff (rst)
        rvalid_2_i |-> !$isunknown(rdata_2_i))
        else $error("port 2 data has unknown bits");

    quiet_in_reset: assert property (@(posedge clk)
        rst && $past(rst) |-> !rvalid_1_i && !rvalid_2_i)
        else $error("valid pulse during reset");

endmodule

`default_nettype wire

// File: verif/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD = 40
) (
    output logic clk
);
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

endmodule

`default_nettype wire

// File: hw/ifetch_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_macros.svh"

module ifetch_top
    import cache_pkg::*;
    import tlb_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,

    input  logic                      rreq_1_i,
    input  fetch_addr_u               raddr_1_i,
    output logic                      rvalid_1_o,
    output logic [`ICACHE_LINE_W-1:0] rdata_1_o,

    input  logic                      rreq_2_i,
    input  fetch_addr_u               raddr_2_i,
    output logic                      rvalid_2_o,
    output logic [`ICACHE_LINE_W-1:0] rdata_2_o,

    input  tlb_req_t                  tlb_req_i,
    input  tlb_wr_t                   tlb_wr_i,

    output mem_req_t                  mem_req_o,
    input  mem_rsp_t                  mem_rsp_i
);
    tlb_res_t tlb_res;
    logic     fetch_any;

    // Either port starts a translation
    assign fetch_any = rreq_1_i | rreq_2_i;

    itlb u_itlb (
        .clk    (clk),
        .rst    (rst),
        .req_i  (tlb_req_i),
        .fetch_i(fetch_any),
        .wr_i   (tlb_wr_i),
        .res_o  (tlb_res)
    );

    icache u_icache (
        .clk       (clk),
        .rst       (rst),
        .rreq_1_i  (rreq_1_i),
        .raddr_1_i (raddr_1_i),
        .rvalid_1_o(rvalid_1_o),
        .rdata_1_o (rdata_1_o),
        .rreq_2_i  (rreq_2_i),
        .raddr_2_i (raddr_2_i),
        .rvalid_2_o(rvalid_2_o),
        .rdata_2_o (rdata_2_o),
        .tlb_req_i (tlb_req_i),
        .tlb_i     (tlb_res),
        .mem_req_o (mem_req_o),
        .mem_rsp_i (mem_rsp_i)
    );

endmodule

`default_nettype wire

// File: hw/icache.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_macros.svh"

module icache
    import cache_pkg::*;
    import tlb_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,

    input  logic                      rreq_1_i,
    input  fetch_addr_u               raddr_1_i,
    output logic                      rvalid_1_o,
    output logic [`ICACHE_LINE_W-1:0] rdata_1_o,

    input  logic                      rreq_2_i,
    input  fetch_addr_u               raddr_2_i,
    output logic                      rvalid_2_o,
    output logic [`ICACHE_LINE_W-1:0] rdata_2_o,

    input  tlb_req_t                  tlb_req_i,
    input  tlb_res_t                  tlb_i,

    output mem_req_t                  mem_req_o,
    input  mem_rsp_t                  mem_rsp_i
);
    localparam int NWAY   = `ICACHE_NWAY;
    localparam int WAY_W  = $clog2(NWAY);
    localparam int LINE_W = `ICACHE_LINE_W;
    localparam int TE_W   = $bits(tag_entry_t);

    typedef enum logic [2:0] {
        IDLE,
        REFILL_1_REQ,
        REFILL_1_WAIT,
        REFILL_2_REQ,
        REFILL_2_WAIT
    } state_t;

    state_t state, next_state;

    // Index 0 is fetch port 1, index 1 is fetch port 2
    logic [1:0]        rreq;
    fetch_addr_u       raddr   [2];
    logic [1:0]        p1_req;
    logic [1:0]        p1_new;
    logic [1:0]        p1_ten;
    fetch_addr_u       p1_addr [2];
    tlb_res_t          trans   [2];
    tlb_res_t          trans_r [2];
    logic [1:0]        hold;
    logic [1:0]        tmiss;
    logic [1:0]        hit;
    logic [1:0]        need;
    logic [1:0]        rvalid;
    logic [LINE_W-1:0] rdata   [2];
    logic [SET_W-1:0]  set_idx [2];

    logic [TE_W-1:0]   tag_rd  [NWAY][2];
    logic [LINE_W-1:0] data_rd [NWAY][2];
    logic              way_we  [NWAY][2];
    tag_entry_t        tag_wr;
    logic [7:0]        lfsr_val;
    logic [WAY_W-1:0]  victim;

    assign rreq = {rreq_2_i, rreq_1_i};
    assign raddr[0] = raddr_1_i;
    assign raddr[1] = raddr_2_i;

    //////////////////////////////////////////////////////////////////////
    // Stage 0 RAM indexing
    //////////////////////////////////////////////////////////////////////

    // Held ports re-read their own set every cycle
    always_comb begin
        for (int p = 0; p < 2; p++) begin
            hold[p] = p1_req[p] & ~rvalid[p];
            set_idx[p] = hold[p] ? p1_addr[p].cache.set : raddr[p].cache.set;
        end
    end

    for (genvar w = 0; w < NWAY; w++) begin : g_way
        dp_bram #(
            .DATA_W   (TE_W),
            .DEPTH_EXP(SET_W)
        ) u_tag_ram (
            .clk    (clk),
            .wea_i  (way_we[w][0]),
            .web_i  (way_we[w][1]),
            .dina_i (tag_wr),
            .dinb_i (tag_wr),
            .addra_i(set_idx[0]),
            .addrb_i(set_idx[1]),
            .douta_o(tag_rd[w][0]),
            .doutb_o(tag_rd[w][1])
        );

        dp_bram #(
            .DATA_W   (LINE_W),
            .DEPTH_EXP(SET_W)
        ) u_data_ram (
            .clk    (clk),
            .wea_i  (way_we[w][0]),
            .web_i  (way_we[w][1]),
            .dina_i (mem_rsp_i.data),
            .dinb_i (mem_rsp_i.data),
            .addra_i(set_idx[0]),
            .addrb_i(set_idx[1]),
            .douta_o(data_rd[w][0]),
            .doutb_o(data_rd[w][1])
        );
    end

    //////////////////////////////////////////////////////////////////////
    // Stage 1 tag compare and output
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            p1_req <= '0;
            p1_new <= '0;
        end else begin
            for (int p = 0; p < 2; p++) begin
                if (!hold[p]) begin
                    p1_req[p] <= rreq[p];
                end
                p1_new[p] <= ~hold[p] & rreq[p];
            end
        end
    end

    // Translation is kept per port from its first stage-1 cycle
    always_ff @(posedge clk) begin
        for (int p = 0; p < 2; p++) begin
            if (!hold[p]) begin
                p1_addr[p] <= raddr[p];
                p1_ten[p] <= tlb_req_i.trans_en;
            end
            trans_r[p] <= trans[p];
        end
    end

    always_comb begin
        tag_entry_t entry;
        for (int p = 0; p < 2; p++) begin
            trans[p] = p1_new[p] ? tlb_i : trans_r[p];
            tmiss[p] = p1_req[p] & p1_ten[p] & ~trans[p].found;
            hit[p] = 1'b0;
            rdata[p] = '0;
            for (int w = 0; w < NWAY; w++) begin
                entry = tag_rd[w][p];
                if (entry.valid && entry.tag == trans[p].tag && !tmiss[p]) begin
                    hit[p] = p1_req[p];
                    rdata[p] = data_rd[w][p];
                end
            end
            need[p] = p1_req[p] & ~tmiss[p] & ~hit[p];
            rvalid[p] = tmiss[p] | hit[p];
        end
    end

    assign rvalid_1_o = rvalid[0];
    assign rvalid_2_o = rvalid[1];
    assign rdata_1_o = rdata[0];
    assign rdata_2_o = rdata[1];

    //////////////////////////////////////////////////////////////////////
    // Refill
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (need[0]) begin
                    next_state = REFILL_1_REQ;
                end else if (need[1]) begin
                    next_state = REFILL_2_REQ;
                end
            end
            REFILL_1_REQ: begin
                if (mem_rsp_i.rdy) next_state = REFILL_1_WAIT;
            end
            REFILL_1_WAIT: begin
                // Line read back and port 1 done
                if (!need[0]) next_state = need[1] ? REFILL_2_REQ : IDLE;
            end
            REFILL_2_REQ: begin
                // Port 2 may already hit on the line port 1 brought in
                if (!need[1]) begin
                    next_state = IDLE;
                end else if (mem_rsp_i.rdy) begin
                    next_state = REFILL_2_WAIT;
                end
            end
            REFILL_2_WAIT: begin
                if (!need[1]) next_state = IDLE;
            end
            default: next_state = IDLE;
        endcase
    end

    always_comb begin
        mem_req_o = '0;
        case (state)
            REFILL_1_REQ, REFILL_1_WAIT: begin
                mem_req_o.req = need[0] & ~mem_rsp_i.rvalid;
                mem_req_o.addr = {trans[0].tag, p1_addr[0].page.offset};
            end
            REFILL_2_REQ, REFILL_2_WAIT: begin
                mem_req_o.req = need[1] & ~mem_rsp_i.rvalid;
                mem_req_o.addr = {trans[1].tag, p1_addr[1].page.offset};
            end
            default: begin
            end
        endcase
    end

    lfsr #(
        .WIDTH(8)
    ) u_lfsr (
        .clk    (clk),
        .rst    (rst),
        .value_o(lfsr_val)
    );

    assign victim = lfsr_val[WAY_W-1:0];

    assign tag_wr.valid = 1'b1;
    assign tag_wr.tag = (state == REFILL_2_WAIT) ? trans[1].tag : trans[0].tag;

    // Returned line goes into the victim way through the refilling port
    always_comb begin
        for (int w = 0; w < NWAY; w++) begin
            way_we[w][0] = mem_rsp_i.rvalid && state == REFILL_1_WAIT
                           && WAY_W'(w) == victim;
            way_we[w][1] = mem_rsp_i.rvalid && state == REFILL_2_WAIT
                           && WAY_W'(w) == victim;
        end
    end

endmodule

`default_nettype wire

// File: hw/itlb.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_macros.svh"

module itlb
    import cache_pkg::*;
    import tlb_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  tlb_req_t req_i,
    input  logic     fetch_i,
    input  tlb_wr_t  wr_i,
    output tlb_res_t res_o
);
    logic                     ent_valid [`ITLB_ENTRIES];
    logic [`ICACHE_TAG_W-1:0] ent_vpn   [`ITLB_ENTRIES];
    logic [`ICACHE_TAG_W-1:0] ent_ppn   [`ITLB_ENTRIES];

    fetch_addr_u              va;
    logic                     lk_found;
    logic [`ICACHE_TAG_W-1:0] lk_ppn;

    assign va = req_i.vaddr;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `ITLB_ENTRIES; i++) begin
                ent_valid[i] <= 1'b0;
            end
        end else if (wr_i.we) begin
            ent_valid[wr_i.idx] <= wr_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_i.we) begin
            ent_vpn[wr_i.idx] <= wr_i.vpn;
            ent_ppn[wr_i.idx] <= wr_i.ppn;
        end
    end

    // Fully associative match on the page number
    always_comb begin
        lk_found = 1'b0;
        lk_ppn = '0;
        for (int i = 0; i < `ITLB_ENTRIES; i++) begin
            if (ent_valid[i] && ent_vpn[i] == va.page.vpn) begin
                lk_found = 1'b1;
                lk_ppn = ent_ppn[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            res_o <= '0;
        end else if (fetch_i) begin
            if (req_i.trans_en) begin
                res_o.found <= lk_found;
                res_o.tag <= lk_ppn;
            end else begin
                // Identity mapping
                res_o.found <= 1'b1;
                res_o.tag <= va.page.vpn;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/lfsr.sv
`timescale 1ns/1ps
`default_nettype none

module lfsr #(
    parameter int WIDTH = 8
) (
    input  logic             clk,
    input  logic             rst,
    output logic [WIDTH-1:0] value_o
);
    // Maximal-length feedback for 3 to 8 bits
    localparam logic [WIDTH-1:0] TAPS =
        (WIDTH == 3) ? WIDTH'(3'b110) :
        (WIDTH == 4) ? WIDTH'(4'b1100) :
        (WIDTH == 5) ? WIDTH'(5'b10100) :
        (WIDTH == 6) ? WIDTH'(6'b110000) :
        (WIDTH == 7) ? WIDTH'(7'b1100000) : WIDTH'(8'hB8);

    always_ff @(posedge clk) begin
        if (rst) begin
            value_o <= WIDTH'(1);
        end else begin
            value_o <= (value_o >> 1) ^ (value_o[0] ? TAPS : '0);
        end
    end

endmodule

`default_nettype wire

// File: hw/dp_bram.sv
`timescale 1ns/1ps
`default_nettype none

module dp_bram #(
    parameter int DATA_W    = 32,
    parameter int DEPTH_EXP = 8
) (
    input  logic                 clk,
    input  logic                 wea_i,
    input  logic                 web_i,
    input  logic [DATA_W-1:0]    dina_i,
    input  logic [DATA_W-1:0]    dinb_i,
    input  logic [DEPTH_EXP-1:0] addra_i,
    input  logic [DEPTH_EXP-1:0] addrb_i,
    output logic [DATA_W-1:0]    douta_o,
    output logic [DATA_W-1:0]    doutb_o
);
    localparam int DEPTH = 1 << DEPTH_EXP;

    logic [DATA_W-1:0] mem [DEPTH];

    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    // Write-first on both ports
    always @(posedge clk) begin
        if (wea_i) begin
            mem[addra_i] <= dina_i;
            douta_o <= dina_i;
        end else begin
            douta_o <= mem[addra_i];
        end
        if (web_i) begin
            mem[addrb_i] <= dinb_i;
            doutb_o <= dinb_i;
        end else begin
            doutb_o <= mem[addrb_i];
        end
    end

endmodule

`default_nettype wire

// File: hw/tlb_pkg.sv
`default_nettype none

`include "icache_macros.svh"

package tlb_pkg;

    localparam int TLB_IDX_W = $clog2(`ITLB_ENTRIES);

    // Sent with every fetch
    typedef struct packed {
        logic                      trans_en;
        logic [`ICACHE_ADDR_W-1:0] vaddr;
    } tlb_req_t;

    // Registered lookup result
    typedef struct packed {
        logic                     found;
        logic [`ICACHE_TAG_W-1:0] tag;
    } tlb_res_t;

    // Entry update
    typedef struct packed {
        logic                     we;
        logic [TLB_IDX_W-1:0]     idx;
        logic                     valid;
        logic [`ICACHE_TAG_W-1:0] vpn;
        logic [`ICACHE_TAG_W-1:0] ppn;
    } tlb_wr_t;

endpackage

`default_nettype wire

// File: hw/cache_pkg.sv
`default_nettype none

`include "icache_macros.svh"

package cache_pkg;

    localparam int PAGE_OFF_W = `ICACHE_ADDR_W - `ICACHE_TAG_W;
    localparam int BYTE_OFF_W = $clog2(`ICACHE_LINE_W / 8);
    localparam int SET_W = $clog2(`ICACHE_NSET);

    // Page view, used for translation
    typedef struct packed {
        logic [`ICACHE_TAG_W-1:0] vpn;
        logic [PAGE_OFF_W-1:0]    offset;
    } page_view_t;

    // Cache view, used for indexing
    typedef struct packed {
        logic [`ICACHE_TAG_W-1:0] tag;
        logic [SET_W-1:0]         set;
        logic [BYTE_OFF_W-1:0]    byte_off;
    } cache_view_t;

    typedef union packed {
        page_view_t  page;
        cache_view_t cache;
    } fetch_addr_u;

    typedef struct packed {
        logic                     valid;
        logic [`ICACHE_TAG_W-1:0] tag;
    } tag_entry_t;

    typedef struct packed {
        logic                      req;
        logic [`ICACHE_ADDR_W-1:0] addr;
    } mem_req_t;

    typedef struct packed {
        logic                      rdy;
        logic                      rvalid;
        logic [`ICACHE_LINE_W-1:0] data;
    } mem_rsp_t;

endpackage

`default_nettype wire

// File: hw/icache_macros.svh
`ifndef ICACHE_MACROS_SVH
`define ICACHE_MACROS_SVH

// Fetch address and cache line geometry
`define ICACHE_ADDR_W 32
`define ICACHE_LINE_W 128

// Cache organisation
`define ICACHE_NSET 256
`define ICACHE_NWAY 2

// Physical tag and page number width
`define ICACHE_TAG_W 20

// Instruction TLB size
`define ITLB_ENTRIES 8

`endif
